//--- char_fifo.sv
`timescale 1ns/1ps

module char_fifo #(
  parameter int DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       in_valid,
  input  logic [7:0] in_data,
  output logic       in_ready,

  output logic       out_valid,
  output logic [7:0] out_data,
  input  logic       out_ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          push;
  logic          pop;

  assign full = (count == FULL_CNT);

  // when full a byte may still enter on the cycle one leaves
  assign in_ready  = !full || out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally for a power of two depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= FULL_CNT
  ) else $error("char fifo count above depth");

endmodule

//--- compile.f
+incdir+.
print_pkg.sv
char_fifo.sv
uart_tx.sv
str_iter.sv
print_front.sv
print_uart_top.sv
tb_print_uart.sv

//--- print_front.sv
`timescale 1ns/1ps

`include "print_macros.svh"

module print_front (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        prn_en,
  input  logic [`PRINT_STR_WIDTH-1:0] prn_msg,
  input  print_pkg::msg_kind_e        prn_kind,
  input  logic [3:0]                  prn_bin_len,
  output logic                        prn_busy,

  output logic                        m_valid,
  output logic [`PRINT_STR_WIDTH-1:0] m_msg,
  output print_pkg::msg_kind_e        m_kind,
  output logic [3:0]                  m_bin_len,
  input  logic                        m_ready
);

  // a pending request or one arriving this cycle keeps the client off
  assign prn_busy = m_valid || prn_en;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else begin
      m_valid <= m_valid && !m_ready;
      // new request is latched without looking at valid so the path stays short
      if (prn_en) begin
        m_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prn_en) begin
      m_msg     <= prn_msg;
      m_kind    <= prn_kind;
      m_bin_len <= prn_bin_len;
    end
  end

  // client must wait for busy to drop before the next request
  a_no_overrun : assert property (
    @(posedge clk) disable iff (!rst_n)
    prn_en |-> !m_valid
  ) else $error("print request arrived while one is pending");

endmodule

//--- print_macros.svh
`ifndef PRINT_MACROS_SVH
`define PRINT_MACROS_SVH

// longest message in bytes
`define PRINT_STR_MAX_LEN 16

// message width in bits
`define PRINT_STR_WIDTH (8 * `PRINT_STR_MAX_LEN)

// character buffer entries, power of two
`define PRINT_FIFO_DEPTH 8

// clock cycles per serial bit
`define PRINT_CLKS_PER_BIT 4

`endif

//--- print_pkg.sv
package print_pkg;

  // message kind carried with each print request
  typedef enum logic {
    MSG_STR = 1'b0,
    MSG_BIN = 1'b1
  } msg_kind_e;

  // string iterator states
  typedef enum logic [1:0] {
    ITER_IDLE = 2'd0,
    ITER_SKIP = 2'd1,
    ITER_EMIT = 2'd2
  } iter_state_e;

  // serial transmitter states
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
  } tx_state_e;

endpackage

//--- print_uart_top.sv
`timescale 1ns/1ps

`include "print_macros.svh"

module print_uart_top (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        prn_en,
  input  logic [`PRINT_STR_WIDTH-1:0] prn_msg,
  input  print_pkg::msg_kind_e        prn_kind,
  input  logic [3:0]                  prn_bin_len,
  output logic                        prn_busy,

  output logic                        txd
);

  logic                        m_valid;
  logic [`PRINT_STR_WIDTH-1:0] m_msg;
  print_pkg::msg_kind_e        m_kind;
  logic [3:0]                  m_bin_len;
  logic                        m_ready;

  logic                        ch_valid;
  logic [7:0]                  ch_data;
  logic                        ch_ready;

  logic                        tx_valid;
  logic [7:0]                  tx_data;
  logic                        tx_ready;

  print_front i_front (
    .clk         (clk),
    .rst_n       (rst_n),
    .prn_en      (prn_en),
    .prn_msg     (prn_msg),
    .prn_kind    (prn_kind),
    .prn_bin_len (prn_bin_len),
    .prn_busy    (prn_busy),
    .m_valid     (m_valid),
    .m_msg       (m_msg),
    .m_kind      (m_kind),
    .m_bin_len   (m_bin_len),
    .m_ready     (m_ready)
  );

  str_iter i_iter (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (m_valid),
    .s_msg     (m_msg),
    .s_kind    (m_kind),
    .s_bin_len (m_bin_len),
    .s_ready   (m_ready),
    .m_valid   (ch_valid),
    .m_char    (ch_data),
    .m_ready   (ch_ready)
  );

  // absorbs bursts from the iterator while the serial line drains
  char_fifo #(
    .DEPTH (`PRINT_FIFO_DEPTH)
  ) i_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ch_valid),
    .in_data   (ch_data),
    .in_ready  (ch_ready),
    .out_valid (tx_valid),
    .out_data  (tx_data),
    .out_ready (tx_ready)
  );

  uart_tx i_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (tx_valid),
    .s_data  (tx_data),
    .s_ready (tx_ready),
    .txd     (txd)
  );

endmodule

//--- str_iter.sv
`timescale 1ns/1ps

`include "print_macros.svh"

module str_iter (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        s_valid,
  input  logic [`PRINT_STR_WIDTH-1:0] s_msg,
  input  print_pkg::msg_kind_e        s_kind,
  input  logic [3:0]                  s_bin_len,
  output logic                        s_ready,

  output logic                        m_valid,
  output logic [7:0]                  m_char,
  input  logic                        m_ready
);

  localparam int CNT_W = $clog2(`PRINT_STR_MAX_LEN + 1);
  localparam int SH_W  = $clog2(`PRINT_STR_WIDTH) + 1;

  print_pkg::iter_state_e      state;
  logic [`PRINT_STR_WIDTH-1:0] shreg;
  logic [CNT_W-1:0]            remain;
  logic [CNT_W-1:0]            len_clip;
  logic [SH_W-1:0]             bin_shift;
  logic [7:0]                  top_byte;
  logic                        accept;
  logic                        skip_zero;
  logic                        emit;

  assign top_byte = shreg[`PRINT_STR_WIDTH-1 -: 8];

  assign s_ready = (state == print_pkg::ITER_IDLE);
  assign accept  = s_valid && s_ready;
  assign m_valid = (state == print_pkg::ITER_EMIT);
  assign m_char  = top_byte;
  assign emit    = m_valid && m_ready;

  // drop one leading zero byte per cycle while bytes remain
  assign skip_zero = (state == print_pkg::ITER_SKIP) && (remain != '0) && (top_byte == 8'h00);

  always_comb begin
    if (s_bin_len > `PRINT_STR_MAX_LEN) begin
      len_clip = CNT_W'(`PRINT_STR_MAX_LEN);
    end else begin
      len_clip = CNT_W'(s_bin_len);
    end
  end

  // binary bytes get moved up to the msb end of the shift register
  assign bin_shift = SH_W'(8 * (`PRINT_STR_MAX_LEN - int'(len_clip)));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= print_pkg::ITER_IDLE;
      remain <= '0;
    end else begin
      case (state)
        print_pkg::ITER_IDLE: begin
          if (accept) begin
            if (s_kind == print_pkg::MSG_STR) begin
              remain <= CNT_W'(`PRINT_STR_MAX_LEN);
              state  <= print_pkg::ITER_SKIP;
            end else begin
              remain <= len_clip;
              state  <= (len_clip == '0) ? print_pkg::ITER_IDLE : print_pkg::ITER_EMIT;
            end
          end
        end
        print_pkg::ITER_SKIP: begin
          if (remain == '0) begin
            // all zero string has nothing to send
            state <= print_pkg::ITER_IDLE;
          end else if (top_byte != 8'h00) begin
            state <= print_pkg::ITER_EMIT;
          end else begin
            remain <= remain - 1'b1;
          end
        end
        print_pkg::ITER_EMIT: begin
          if (emit) begin
            remain <= remain - 1'b1;
            if (remain == CNT_W'(1)) begin
              state <= print_pkg::ITER_IDLE;
            end
          end
        end
        default: begin
          state <= print_pkg::ITER_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (s_kind == print_pkg::MSG_STR) begin
        shreg <= s_msg;
      end else begin
        shreg <= s_msg << bin_shift;
      end
    end else if (skip_zero || emit) begin
      shreg <= shreg << 8;
    end
  end

  a_char_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_char))
  ) else $error("iterator changed its byte while stalled");

  // a new message is only taken once every byte of the last one is gone
  a_ready_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    s_ready |-> (remain == '0)
  ) else $error("iterator ready with bytes still to send");

endmodule

//--- tb_print_uart.sv
`timescale 1ns/1ps

`include "print_macros.svh"

module tb_print_uart;

  localparam int MAX_LEN = `PRINT_STR_MAX_LEN;
  localparam int CPB     = `PRINT_CLKS_PER_BIT;
  localparam int N_MSG   = 47;
  localparam int N_TESTS = 6;

  logic                        clk;
  logic                        rst_n;
  logic                        prn_en;
  logic [`PRINT_STR_WIDTH-1:0] prn_msg;
  print_pkg::msg_kind_e        prn_kind;
  logic [3:0]                  prn_bin_len;
  logic                        prn_busy;
  logic                        txd;

  logic [`PRINT_STR_WIDTH-1:0] msg_a [N_MSG];
  print_pkg::msg_kind_e        kind_a [N_MSG];
  logic [3:0]                  len_a [N_MSG];

  logic [7:0] rx_q [$];
  logic [7:0] exp_q [$];
  logic       rx_busy;
  int         rx_total;
  int         errors;
  int         test_exp;
  int         total_exp;
  int         cycles;
  int         cycle_limit;
  int         ok_tests;
  int         bad_tests;

  print_uart_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .prn_en      (prn_en),
    .prn_msg     (prn_msg),
    .prn_kind    (prn_kind),
    .prn_bin_len (prn_bin_len),
    .prn_busy    (prn_busy),
    .txd         (txd)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_line(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  // appends the bytes the print path should send to exp_q and returns their number
  function automatic int expected_bytes(input logic [`PRINT_STR_WIDTH-1:0] msg,
                                        input print_pkg::msg_kind_e kind,
                                        input logic [3:0] bin_len);
    int n;
    int first;
    n = 0;
    first = -1;
    if (kind == print_pkg::MSG_STR) begin
      for (int i = MAX_LEN - 1; i >= 0; i--) begin
        if (first < 0 && msg[8*i +: 8] != 8'h00) begin
          first = i;
        end
      end
    end else begin
      first = int'(bin_len);
      if (first > MAX_LEN) begin
        first = MAX_LEN;
      end
      first = first - 1;
    end
    for (int i = first; i >= 0; i--) begin
      exp_q.push_back(msg[8*i +: 8]);
      n++;
    end
    return n;
  endfunction

  // serial decoder samples at mid-bit on the falling clock edge
  initial begin : rx_decode
    logic [7:0] b;
    rx_busy = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && txd === 1'b0) begin
        rx_busy = 1'b1;
        repeat (CPB / 2) @(negedge clk);
        if (txd !== 1'b0) begin
          $display("start bit did not stay low at %0t ns", $time);
          errors++;
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          b[i] = txd;
        end
        repeat (CPB) @(negedge clk);
        if (txd !== 1'b1) begin
          $display("frame error, stop bit low at %0t ns", $time);
          errors++;
        end
        rx_q.push_back(b);
        rx_busy = 1'b0;
      end
    end
  end

  initial begin : compare
    logic [7:0] act;
    logic [7:0] expv;
    forever begin
      wait (rx_q.size() > 0);
      act = rx_q.pop_front();
      rx_total++;
      if (exp_q.size() == 0) begin
        $display("unexpected extra byte %h received at %0t ns", act, $time);
        errors++;
      end else begin
        expv = exp_q.pop_front();
        check_byte("txd byte", expv, act);
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    @(posedge clk);
    while (cycle_limit == 0 || cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles, iterator in %s", cycles,
             i_dut.i_iter.state.name());
    $display("Regression failed");
    $finish;
  end

  task automatic build_stimulus();
    msg_a[0]  = {"dbg", 8'h00, "ok", 8'h0d, 8'h0a};
    kind_a[0] = print_pkg::MSG_STR;
    len_a[0]  = 4'd0;
    msg_a[1]  = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    msg_a[2]  = 128'h5a5a_5a5a_5a5a_5a5a_5a5a_5a5a_5a5a_00a5;
    msg_a[3]  = 128'hffff_ffff_ffff_ffff_ffff_ffff_1200_0034;
    msg_a[4]  = 128'hee00_1122_0000_3344_5566_0077_8899_00aa;
    len_a[1]  = 4'd1;
    len_a[2]  = 4'd2;
    len_a[3]  = 4'd4;
    len_a[4]  = 4'd15;
    for (int i = 1; i <= 4; i++) begin
      kind_a[i] = print_pkg::MSG_BIN;
    end
    msg_a[5]  = '0;
    kind_a[5] = print_pkg::MSG_STR;
    len_a[5]  = 4'd7;
    msg_a[6]  = '1;
    kind_a[6] = print_pkg::MSG_BIN;
    len_a[6]  = 4'd0;
    // full length strings keep the serial line well behind the iterator
    for (int i = 7; i <= 16; i++) begin
      msg_a[i]  = {$urandom, $urandom, $urandom, $urandom};
      msg_a[i][127:120] = 8'h41 + 8'($urandom % 26);
      kind_a[i] = print_pkg::MSG_STR;
      len_a[i]  = 4'd0;
    end
    for (int i = 17; i < N_MSG; i++) begin
      msg_a[i]  = {$urandom, $urandom, $urandom, $urandom};
      msg_a[i]  = msg_a[i] >> (8 * ($urandom % 17));
      kind_a[i] = print_pkg::msg_kind_e'($urandom % 2);
      len_a[i]  = 4'($urandom % 16);
    end
  endtask

  // waits for a free front, then pulses prn_en for one cycle
  task automatic send_msg(input int idx);
    while (prn_busy) begin
      @(posedge clk);
      #1;
    end
    prn_msg     = msg_a[idx];
    prn_kind    = kind_a[idx];
    prn_bin_len = len_a[idx];
    prn_en      = 1'b1;
    test_exp += expected_bytes(msg_a[idx], kind_a[idx], len_a[idx]);
    @(posedge clk);
    #1;
    prn_en = 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (i_dut.i_front.m_valid || i_dut.i_iter.state != print_pkg::ITER_IDLE ||
               i_dut.tx_valid || !i_dut.tx_ready || rx_busy);
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      ok_tests++;
      $display("test %s: ok", name);
    end else begin
      bad_tests++;
      $display("test %s: FAIL with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic run_test(input string name, input int first, input int last);
    int err_start;
    int rx_start;
    err_start = errors;
    rx_start  = rx_total;
    test_exp  = 0;
    for (int i = first; i <= last; i++) begin
      send_msg(i);
    end
    wait_drain();
    check_count("bytes received", test_exp, rx_total - rx_start);
    check_line("prn_busy", 1'b0, prn_busy);
    check_line("txd", 1'b1, txd);
    if (exp_q.size() != 0) begin
      $display("%0d expected bytes never arrived", exp_q.size());
      errors++;
      exp_q.delete();
    end
    report_test(name, err_start);
    @(posedge clk);
    #1;
  endtask

  initial begin : main
    int err_start;
    rst_n       = 1'b0;
    prn_en      = 1'b0;
    prn_msg     = '0;
    prn_kind    = print_pkg::MSG_STR;
    prn_bin_len = 4'd0;
    rx_total    = 0;
    errors      = 0;
    ok_tests    = 0;
    bad_tests   = 0;
    cycle_limit = 0;
    total_exp   = 0;
    void'($urandom(32'hb0cc4713));
    build_stimulus();
    for (int i = 0; i < N_MSG; i++) begin
      total_exp += expected_bytes(msg_a[i], kind_a[i], len_a[i]);
    end
    exp_q.delete();
    cycle_limit = total_exp * 10 * CPB + 200 * N_TESTS;

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err_start = errors;
    repeat (20) begin
      @(negedge clk);
      check_line("txd", 1'b1, txd);
      check_line("prn_busy", 1'b0, prn_busy);
    end
    check_count("bytes after reset", 0, rx_total);
    report_test("1 idle after reset", err_start);
    @(posedge clk);
    #1;

    run_test("2 string with leading zeros", 0, 0);
    run_test("3 binary lengths", 1, 4);
    run_test("4 empty messages", 5, 6);
    run_test("5 back-pressure", 7, 16);
    run_test("6 random messages", 17, N_MSG - 1);
    check_count("total bytes", total_exp, rx_total);

    $display("tests ok %0d, tests failing %0d, errors %0d", ok_tests, bad_tests, errors);
    if (errors == 0 && bad_tests == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

`include "print_macros.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       s_valid,
  input  logic [7:0] s_data,
  output logic       s_ready,

  output logic       txd
);

  localparam int CPB = `PRINT_CLKS_PER_BIT;
  localparam int CW  = (CPB > 1) ? $clog2(CPB) : 1;
  localparam logic [CW-1:0] LAST_CLK = CW'(CPB - 1);

  print_pkg::tx_state_e state;
  logic [CW-1:0]        clk_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           data_q;
  logic                 bit_done;

  assign s_ready  = (state == print_pkg::TX_IDLE);
  assign bit_done = (clk_cnt == LAST_CLK);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= print_pkg::TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
      case (state)
        print_pkg::TX_IDLE: begin
          clk_cnt <= '0;
          if (s_valid) begin
            // start bit goes out on this edge
            txd   <= 1'b0;
            state <= print_pkg::TX_START;
          end
        end
        print_pkg::TX_START: begin
          if (bit_done) begin
            txd     <= data_q[0];
            bit_idx <= '0;
            state   <= print_pkg::TX_DATA;
          end
        end
        print_pkg::TX_DATA: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;
              state <= print_pkg::TX_STOP;
            end else begin
              // lsb first
              txd     <= data_q[bit_idx + 3'd1];
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end
        print_pkg::TX_STOP: begin
          if (bit_done) begin
            state <= print_pkg::TX_IDLE;
          end
        end
        default: begin
          txd   <= 1'b1;
          state <= print_pkg::TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      data_q <= s_data;
    end
  end

  a_idle_high : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == print_pkg::TX_IDLE) |-> txd
  ) else $error("txd low while transmitter idle");

endmodule
